// ==== rtl/board_params.svh ====
`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// uart bit period in clock cycles
`define CLKS_PER_BIT 8

// counter width for the bit period, good up to 128 clocks per bit
`define BIT_CNT_W 7

// scratch memory depth is 2**MEM_ADDR_W words
`define MEM_ADDR_W 8

// cycles the internal reset is held after rstn drops
`define RST_STRETCH 16

`define RST_CNT_W 5

`endif

// ==== rtl/board_pkg.sv ====
package board_pkg;

    typedef logic [7:0] byte_t;

    // memory view of a command frame
    typedef struct packed {
        byte_t       op;
        byte_t       addr;
        logic [15:0] wdata;
    } mem_cmd_t;

    // gpio view of the same frame
    typedef struct packed {
        byte_t       op;
        byte_t       mode;
        logic [15:0] value;
    } gpio_cmd_t;

    // first byte on the wire ends up as op in the top byte
    typedef union packed {
        mem_cmd_t  mem;
        gpio_cmd_t gpio;
    } cmd_word_t;

    typedef enum logic [1:0] {
        KIND_MEM_WR,
        KIND_MEM_RD,
        KIND_GPIO,
        KIND_BAD
    } cmd_kind_e;

    typedef enum logic [7:0] {
        GPIO_WRITE  = 8'd0,
        GPIO_SET    = 8'd1,
        GPIO_CLEAR  = 8'd2,
        GPIO_TOGGLE = 8'd3
    } gpio_mode_e;

    localparam byte_t STATUS_BAD = 8'hEE;

endpackage

// ==== rtl/mem_bus_if.sv ====
`timescale 1ns/100ps
`include "board_params.svh"

// single-port request bus, req is a one-cycle strobe
interface mem_bus_if;

    logic                   req;
    logic                   we;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [15:0]            wdata;
    // valid the cycle after a read strobe
    logic [15:0]            rdata;

    modport master (
        output req,
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    modport slave (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

// ==== rtl/uart_rx.sv ====
`timescale 1ns/100ps
`include "board_params.svh"

module uart_rx (
    input  logic             clk,
    input  logic             rst,
    input  logic             rxd,
    output logic             rx_valid,
    output board_pkg::byte_t rx_byte
);

    localparam logic [`BIT_CNT_W-1:0] BIT_LAST  = `BIT_CNT_W'(`CLKS_PER_BIT - 1);
    localparam logic [`BIT_CNT_W-1:0] HALF_LAST = `BIT_CNT_W'(`CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t             state;
    logic                  rx_meta;
    logic                  rx_sync;
    logic                  rx_prev;
    logic [`BIT_CNT_W-1:0] cnt;
    logic [2:0]            bit_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta  <= 1'b1;
            rx_sync  <= 1'b1;
            rx_prev  <= 1'b1;
            state    <= RX_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end
        else begin
            // two-flop synchronizer, plus one more for edge detect
            rx_meta  <= rxd;
            rx_sync  <= rx_meta;
            rx_prev  <= rx_sync;
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (cnt == HALF_LAST) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        // glitch if the line went back high
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end
                    else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (cnt == BIT_LAST) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                    else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    // mid stop bit, no framing check
                    if (cnt == BIT_LAST) begin
                        rx_valid <= 1'b1;
                        state    <= RX_IDLE;
                    end
                    else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && cnt == BIT_LAST) begin
            rx_byte <= {rx_sync, rx_byte[7:1]};
        end
    end

endmodule

// ==== rtl/uart_tx.sv ====
`timescale 1ns/100ps
`include "board_params.svh"

module uart_tx (
    input  logic             clk,
    input  logic             rst,
    input  logic             tx_start,
    input  board_pkg::byte_t tx_byte,
    output logic             tx_busy,
    output logic             txd
);

    localparam logic [`BIT_CNT_W-1:0] BIT_LAST = `BIT_CNT_W'(`CLKS_PER_BIT - 1);

    logic [9:0]            frame;
    logic [`BIT_CNT_W-1:0] cnt;
    logic [3:0]            bit_cnt;
    logic                  active;
    logic                  last_tick;

    // last cycle of the stop bit, a new byte may load here
    assign last_tick = active && bit_cnt == 4'd9 && cnt == BIT_LAST;
    assign tx_busy   = active && !last_tick;

    // idle frame is all ones so the line rests high
    assign txd = frame[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            frame   <= '1;
            active  <= 1'b0;
            cnt     <= '0;
            bit_cnt <= '0;
        end
        else if (tx_start && !tx_busy) begin
            frame   <= {1'b1, tx_byte, 1'b0};
            active  <= 1'b1;
            cnt     <= '0;
            bit_cnt <= '0;
        end
        else if (active) begin
            if (cnt == BIT_LAST) begin
                cnt   <= '0;
                frame <= {1'b1, frame[9:1]};
                if (bit_cnt == 4'd9) begin
                    active <= 1'b0;
                end
                else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
            else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/cmd_decode.sv ====
`timescale 1ns/100ps

module cmd_decode (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rxd,
    output logic                 cmd_valid,
    output board_pkg::cmd_word_t cmd,
    output board_pkg::cmd_kind_e kind
);

    logic                 rx_valid;
    board_pkg::byte_t     rx_byte;
    logic [1:0]           byte_cnt;
    board_pkg::byte_t     op_byte;
    board_pkg::cmd_kind_e kind_next;

    uart_rx u_uart_rx (
        .clk      (clk),
        .rst      (rst),
        .rxd      (rxd),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte)
    );

    // before the last shift, byte 0 sits one byte below the top
    assign op_byte = cmd[23:16];

    always_comb begin
        case (op_byte)
            8'h01:   kind_next = board_pkg::KIND_MEM_WR;
            8'h02:   kind_next = board_pkg::KIND_MEM_RD;
            8'h03:   kind_next = board_pkg::KIND_GPIO;
            default: kind_next = board_pkg::KIND_BAD;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_cnt  <= '0;
            cmd_valid <= 1'b0;
            kind      <= board_pkg::KIND_BAD;
        end
        else begin
            cmd_valid <= 1'b0;
            if (rx_valid) begin
                byte_cnt <= byte_cnt + 1'b1;
                if (byte_cnt == 2'd3) begin
                    cmd_valid <= 1'b1;
                    kind      <= kind_next;
                end
            end
        end
    end

    // frame shifts in msb byte first
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            cmd <= {cmd[23:0], rx_byte};
        end
    end

endmodule

// ==== rtl/cmd_execute.sv ====
`timescale 1ns/100ps

module cmd_execute (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cmd_valid,
    input  board_pkg::cmd_word_t cmd,
    input  board_pkg::cmd_kind_e kind,
    mem_bus_if.master            mem,
    output logic [15:0]          gpio,
    output logic                 rsp_valid,
    output board_pkg::byte_t     rsp_status,
    output logic [15:0]          rsp_data
);

    logic [15:0]          gpio_next;
    logic                 act_valid;
    board_pkg::cmd_kind_e act_kind;
    board_pkg::byte_t     act_status;
    logic [15:0]          act_data;
    logic                 rsp_is_read;
    logic [15:0]          rsp_hold;

    // unknown modes keep the register as is
    always_comb begin
        case (cmd.gpio.mode)
            board_pkg::GPIO_WRITE:  gpio_next = cmd.gpio.value;
            board_pkg::GPIO_SET:    gpio_next = gpio | cmd.gpio.value;
            board_pkg::GPIO_CLEAR:  gpio_next = gpio & ~cmd.gpio.value;
            board_pkg::GPIO_TOGGLE: gpio_next = gpio ^ cmd.gpio.value;
            default:                gpio_next = gpio;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem.req   <= 1'b0;
            act_valid <= 1'b0;
            rsp_valid <= 1'b0;
            gpio      <= '0;
        end
        else begin
            mem.req   <= cmd_valid && (kind == board_pkg::KIND_MEM_WR ||
                                       kind == board_pkg::KIND_MEM_RD);
            act_valid <= cmd_valid;
            rsp_valid <= act_valid;
            if (cmd_valid && kind == board_pkg::KIND_GPIO) begin
                gpio <= gpio_next;
            end
        end
    end

    // stage 1, memory request and response fields
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            mem.we     <= kind == board_pkg::KIND_MEM_WR;
            mem.addr   <= cmd.mem.addr;
            mem.wdata  <= cmd.mem.wdata;
            act_kind   <= kind;
            act_status <= (kind == board_pkg::KIND_BAD) ? board_pkg::STATUS_BAD : cmd.mem.op;
            case (kind)
                board_pkg::KIND_MEM_WR: act_data <= cmd.mem.wdata;
                board_pkg::KIND_GPIO:   act_data <= gpio_next;
                default:                act_data <= '0;
            endcase
        end
    end

    // stage 2, read data arrives from the memory this cycle
    always_ff @(posedge clk) begin
        if (act_valid) begin
            rsp_status  <= act_status;
            rsp_is_read <= act_kind == board_pkg::KIND_MEM_RD;
            rsp_hold    <= act_data;
        end
    end

    assign rsp_data = rsp_is_read ? mem.rdata : rsp_hold;

endmodule

// ==== rtl/scratch_sram.sv ====
`timescale 1ns/100ps
`include "board_params.svh"

module scratch_sram (
    input  logic     clk,
    mem_bus_if.slave mem
);

    localparam int DEPTH = 1 << `MEM_ADDR_W;

    logic [15:0] ram [DEPTH];

    // write at the strobe edge, read data one cycle later
    always_ff @(posedge clk) begin
        if (mem.req) begin
            if (mem.we) begin
                ram[mem.addr] <= mem.wdata;
            end
            else begin
                mem.rdata <= ram[mem.addr];
            end
        end
    end

endmodule

// ==== rtl/result_encode.sv ====
`timescale 1ns/100ps

module result_encode (
    input  logic             clk,
    input  logic             rst,
    input  logic             rsp_valid,
    input  board_pkg::byte_t rsp_status,
    input  logic [15:0]      rsp_data,
    output logic             txd,
    output logic             busy
);

    logic             tx_start;
    board_pkg::byte_t tx_byte;
    logic             tx_busy;
    logic             active;
    logic [1:0]       byte_idx;
    logic [15:0]      data_q;

    // status goes straight out, the data bytes follow from the latch
    assign tx_start = rsp_valid || (active && !tx_busy);
    assign busy     = active || tx_busy;

    always_comb begin
        if (rsp_valid) begin
            tx_byte = rsp_status;
        end
        else if (byte_idx == 2'd1) begin
            tx_byte = data_q[15:8];
        end
        else begin
            tx_byte = data_q[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            byte_idx <= '0;
        end
        else if (rsp_valid) begin
            active   <= 1'b1;
            byte_idx <= 2'd1;
        end
        else if (active && !tx_busy) begin
            if (byte_idx == 2'd2) begin
                active   <= 1'b0;
                byte_idx <= '0;
            end
            else begin
                byte_idx <= byte_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_valid) begin
            data_q <= rsp_data;
        end
    end

    uart_tx u_uart_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .tx_busy  (tx_busy),
        .txd      (txd)
    );

endmodule

// ==== rtl/board_top.sv ====
`timescale 1ns/100ps
`include "board_params.svh"

module board_top (
    input  logic        clk,
    input  logic        rstn,
    input  logic        rs_rx,
    output logic        rs_tx,
    output logic [15:0] gpio_io
);

    localparam logic [`RST_CNT_W-1:0] RST_LAST = `RST_CNT_W'(`RST_STRETCH - 1);

    logic                  rst;
    logic [`RST_CNT_W-1:0] rst_cnt;

    logic                 cmd_valid;
    board_pkg::cmd_word_t cmd;
    board_pkg::cmd_kind_e kind;

    logic             rsp_valid;
    board_pkg::byte_t rsp_status;
    logic [15:0]      rsp_data;
    logic             enc_busy;

    // reset stretcher, rstn high holds everything in reset
    always_ff @(posedge clk) begin
        if (rstn) begin
            rst_cnt <= '0;
            rst     <= 1'b1;
        end
        else if (rst_cnt == RST_LAST) begin
            rst <= 1'b0;
        end
        else begin
            rst_cnt <= rst_cnt + 1'b1;
        end
    end

    mem_bus_if mem_bus ();

    cmd_decode u_cmd_decode (
        .clk       (clk),
        .rst       (rst),
        .rxd       (rs_rx),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .kind      (kind)
    );

    cmd_execute u_cmd_execute (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .kind       (kind),
        .mem        (mem_bus.master),
        .gpio       (gpio_io),
        .rsp_valid  (rsp_valid),
        .rsp_status (rsp_status),
        .rsp_data   (rsp_data)
    );

    scratch_sram u_scratch_sram (
        .clk (clk),
        .mem (mem_bus.slave)
    );

    // busy only watched by the checkers, a frame always outlasts a response
    result_encode u_result_encode (
        .clk        (clk),
        .rst        (rst),
        .rsp_valid  (rsp_valid),
        .rsp_status (rsp_status),
        .rsp_data   (rsp_data),
        .txd        (rs_tx),
        .busy       (enc_busy)
    );

endmodule

// ==== dv/board_props.sv ====
`timescale 1ns/100ps

module board_props (
    input logic        clk,
    input logic        rst,
    input logic        rs_tx,
    input logic [15:0] gpio_io,
    input logic        cmd_valid,
    input logic        rsp_valid,
    input logic        enc_busy,
    input logic        mem_req
);

    logic reset_fail = 1'b0;
    logic busy_fail  = 1'b0;
    logic lat_fail   = 1'b0;
    logic req_fail   = 1'b0;
    logic fail_seen;

    assign fail_seen = reset_fail | busy_fail | lat_fail | req_fail;

    // outputs settle one cycle into reset
    reset_idle: assert property (@(posedge clk) rst && $past(rst) |-> rs_tx && gpio_io == '0)
        else begin reset_fail = 1'b1; $error("outputs not idle during reset"); end

    // a frame outlasts a response, so the encoder is free
    rsp_when_idle: assert property (@(posedge clk) disable iff (rst)
                                    $rose(rsp_valid) |-> !enc_busy)
        else begin busy_fail = 1'b1; $error("response arrived while encoder busy"); end

    rsp_after_cmd: assert property (@(posedge clk) disable iff (rst)
                                    cmd_valid |-> ##2 rsp_valid)
        else begin lat_fail = 1'b1; $error("rsp_valid missing two cycles after cmd_valid"); end

    rsp_from_cmd: assert property (@(posedge clk) disable iff (rst)
                                   rsp_valid |-> $past(cmd_valid, 2))
        else begin lat_fail = 1'b1; $error("rsp_valid without cmd_valid two cycles before"); end

    req_single: assert property (@(posedge clk) disable iff (rst) mem_req |=> !mem_req)
        else begin req_fail = 1'b1; $error("mem req held for two cycles"); end

endmodule

bind board_top board_props u_props (
    .clk       (clk),
    .rst       (rst),
    .rs_tx     (rs_tx),
    .gpio_io   (gpio_io),
    .cmd_valid (cmd_valid),
    .rsp_valid (rsp_valid),
    .enc_busy  (enc_busy),
    .mem_req   (mem_bus.req)
);

// ==== dv/tb_board.sv ====
`timescale 1ns/100ps
`include "board_params.svh"

module tb_board;

    localparam int START_TIMEOUT = 40 * `CLKS_PER_BIT;
    localparam int RESET_TIMEOUT = 4 * `RST_STRETCH;

    logic        clk = 1'b0;
    logic        rstn;
    logic        rs_rx;
    logic        rs_tx;
    logic [15:0] gpio_io;

    logic [31:0] rng;
    logic [15:0] mem_model [256];
    logic [7:0]  wr_addr [20];
    logic [15:0] gpio_model;

    board_top u_dut (
        .clk     (clk),
        .rstn    (rstn),
        .rs_rx   (rs_rx),
        .rs_tx   (rs_tx),
        .gpio_io (gpio_io)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    // expected register value from the gpio mode rule
    function automatic logic [15:0] next_gpio(input logic [15:0] cur, input logic [7:0] mode,
                                              input logic [15:0] value);
        case (mode)
            8'd0:    return value;
            8'd1:    return cur | value;
            8'd2:    return cur & ~value;
            8'd3:    return cur ^ value;
            default: return cur;
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] got);
        assert (got === exp) else begin
            abort_run($sformatf("Mismatch %s: expected %h, got %h", name, exp, got));
        end
    endtask

    // start bit, 8 data bits lsb first, stop bit
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rs_rx = frame[i];
            repeat (`CLKS_PER_BIT) @(negedge clk);
        end
    endtask

    task automatic recv_byte(output logic [7:0] b);
        int waited;
        waited = 0;
        while (rs_tx !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > START_TIMEOUT) begin
                abort_run("timed out waiting for a start bit on rs_tx");
            end
        end
        // move to the middle of the start bit
        repeat (`CLKS_PER_BIT / 2) @(negedge clk);
        assert (rs_tx === 1'b0) else abort_run("start bit on rs_tx ended early");
        for (int i = 0; i < 8; i++) begin
            repeat (`CLKS_PER_BIT) @(negedge clk);
            b[i] = rs_tx;
        end
        repeat (`CLKS_PER_BIT) @(negedge clk);
        assert (rs_tx === 1'b1) else abort_run("stop bit on rs_tx was low");
    endtask

    task automatic run_command(input logic [7:0] op, input logic [7:0] b1, input logic [7:0] b2,
                               input logic [7:0] b3, input logic [7:0] exp_status,
                               input logic [15:0] exp_data);
        logic [7:0] status;
        logic [7:0] data_hi;
        logic [7:0] data_lo;
        send_byte(op);
        send_byte(b1);
        send_byte(b2);
        send_byte(b3);
        recv_byte(status);
        recv_byte(data_hi);
        recv_byte(data_lo);
        check_value("rsp_status", {8'h00, exp_status}, {8'h00, status});
        check_value("rsp_data", exp_data, {data_hi, data_lo});
    endtask

    // bound checkers raise a flag when one of them fires
    always @(negedge clk) begin
        if (u_dut.u_props.fail_seen === 1'b1) begin
            abort_run("a concurrent assertion in board_props failed");
        end
    end

    initial begin
        int         waited;
        logic [7:0]  addr;
        logic [7:0]  op;
        logic [7:0]  mode;
        logic [15:0] data;
        rstn       = 1'b1;
        rs_rx      = 1'b1;
        rng        = 32'h176a8903;
        gpio_model = '0;
        repeat (10) @(negedge clk);
        rstn = 1'b0;

        // line idle and outputs cleared during the stretch
        waited = 0;
        while (u_dut.rst !== 1'b0) begin
            @(negedge clk);
            check_value("rs_tx", 16'h0001, {15'h0000, rs_tx});
            check_value("gpio_io", 16'h0000, gpio_io);
            waited++;
            if (waited > RESET_TIMEOUT) begin
                abort_run("timed out waiting for the internal reset to release");
            end
        end

        // no response without a command
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            check_value("rs_tx", 16'h0001, {15'h0000, rs_tx});
        end

        for (int i = 0; i < 20; i++) begin
            addr = 8'(xorshift32());
            data = 16'(xorshift32());
            wr_addr[i]      = addr;
            mem_model[addr] = data;
            run_command(8'h01, addr, data[15:8], data[7:0], 8'h01, data);
        end
        for (int i = 0; i < 20; i++) begin
            data = 16'(xorshift32());
            run_command(8'h02, wr_addr[i], data[15:8], data[7:0], 8'h02,
                        mem_model[wr_addr[i]]);
        end

        // each mode twice with random operands
        for (int m = 0; m < 8; m++) begin
            mode       = 8'(m % 4);
            data       = 16'(xorshift32());
            gpio_model = next_gpio(gpio_model, mode, data);
            run_command(8'h03, mode, data[15:8], data[7:0], 8'h03, gpio_model);
            check_value("gpio_io", gpio_model, gpio_io);
        end

        for (int i = 0; i < 3; i++) begin
            mode = 8'h04 + 8'(xorshift32() % 32'd252);
            data = 16'(xorshift32());
            run_command(8'h03, mode, data[15:8], data[7:0], 8'h03, gpio_model);
            check_value("gpio_io", gpio_model, gpio_io);
        end

        // bad opcodes aimed at written addresses and read back afterwards
        for (int i = 0; i < 4; i++) begin
            op = 8'(xorshift32());
            if (op >= 8'h01 && op <= 8'h03) begin
                op = op + 8'h10;
            end
            data = 16'(xorshift32());
            run_command(op, wr_addr[i], data[15:8], data[7:0], 8'hEE, 16'h0000);
            check_value("gpio_io", gpio_model, gpio_io);
            run_command(8'h02, wr_addr[i], 8'h00, 8'h00, 8'h02, mem_model[wr_addr[i]]);
        end

        repeat (2) @(negedge clk);
        if (u_dut.u_props.fail_seen === 1'b1) begin
            abort_run("a concurrent assertion in board_props failed");
        end
        else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

// ==== compile.f ====
+incdir+rtl
rtl/board_pkg.sv
rtl/mem_bus_if.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/cmd_decode.sv
rtl/cmd_execute.sv
rtl/scratch_sram.sv
rtl/result_encode.sv
rtl/board_top.sv
dv/board_props.sv
dv/tb_board.sv

// ==== Makefile ====
TOP = tb_board

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f compile.f --top-module $(TOP) -o $(TOP)

run: compile
	out=$$(./obj_dir/$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
